/* sim.f */
common/gpio_pkg.sv
regs/apb_gpio_regs.sv
logic/gpio_in_sync.sv
logic/gpio_irq.sv
logic/apb_gpio.sv
+incdir+tb
tb/tb_apb_gpio.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_apb_gpio
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "Simulation reported a failure"; exit 1; \
	fi
	@if ! grep -q "TEST PASSED" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb/tb_tasks.svh */
// APB access, random data, wait helpers and directed tests for the GPIO testbench
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
endfunction

task automatic report_mismatch(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
    $display("CHECK FAILED at %0t: %s, got %08h expected %08h", $time, what, got, exp);
    errors++;
endtask

task automatic finish_test(input string name, input int errs_before);
    if (errors == errs_before)
    begin
        pass_count++;
        $display("%-24s pass", name);
    end
    else
    begin
        fail_count++;
        $display("%-24s fail (%0d errors)", name, errors - errs_before);
    end
endtask

task automatic wait_ready();
    int waited;
    waited = 0;
    while (PREADY !== 1'b1 && waited < READY_TIMEOUT)
    begin
        @(negedge HCLK);
        waited++;
    end
    if (PREADY !== 1'b1)
    begin
        $display("Timeout: PREADY stayed low for %0d cycles", READY_TIMEOUT);
        errors++;
    end
endtask

task automatic apb_write(input logic [REG_IDX_WIDTH-1:0] idx, input logic [31:0] data);
    @(negedge HCLK);
    PADDR   = {5'b0, idx, 2'b00};   // Setup cycle
    PWDATA  = data;
    PWRITE  = 1'b1;
    PSEL    = 1'b1;
    PENABLE = 1'b0;
    @(negedge HCLK);
    PENABLE = 1'b1;
    wait_ready();
    if (PSLVERR !== 1'b0)
        report_mismatch("PSLVERR on write", 32'(PSLVERR), 32'd0);
    @(negedge HCLK);
    PSEL    = 1'b0;
    PENABLE = 1'b0;
    PWRITE  = 1'b0;
endtask

task automatic apb_read(input logic [REG_IDX_WIDTH-1:0] idx, output logic [31:0] data);
    @(negedge HCLK);
    PADDR   = {5'b0, idx, 2'b00};
    PWRITE  = 1'b0;
    PSEL    = 1'b1;
    PENABLE = 1'b0;
    @(negedge HCLK);
    PENABLE = 1'b1;
    wait_ready();
    #SAMPLE_DELAY;
    data = PRDATA;   // Settled mid access cycle
    if (PSLVERR !== 1'b0)
        report_mismatch("PSLVERR on read", 32'(PSLVERR), 32'd0);
    @(negedge HCLK);
    PSEL    = 1'b0;
    PENABLE = 1'b0;
endtask

task automatic wait_sync(input pad_vec_t expected);
    int cycles;
    cycles = 0;
    while (gpio_in_sync !== expected && cycles < SYNC_TIMEOUT)
    begin
        @(negedge HCLK);
        cycles++;
    end
    if (gpio_in_sync !== expected)
    begin
        $display("Timeout: gpio_in_sync did not reach %08h within %0d cycles",
                 expected, SYNC_TIMEOUT);
        errors++;
    end
endtask

task automatic watch_irq(input int pad, input bit expect_pulse);
    int cycles;
    bit seen;
    cycles = 0;
    seen   = 1'b0;
    if (expect_pulse)
    begin
        while (!seen && cycles < IRQ_TIMEOUT)
        begin
            @(negedge HCLK);
            cycles++;
            seen = irq;
        end
        if (!seen)
        begin
            $display("Timeout: no interrupt for pad %0d within %0d cycles", pad, IRQ_TIMEOUT);
            errors++;
        end
        else
        begin
            if (cycles != IRQ_LATENCY)
                report_mismatch($sformatf("interrupt latency, pad %0d", pad),
                                32'(cycles), 32'(IRQ_LATENCY));
            @(negedge HCLK);
            if (irq !== 1'b0)
                report_mismatch($sformatf("interrupt width, pad %0d", pad), 32'(irq), 32'd0);
        end
    end
    else
    begin
        while (cycles < IRQ_QUIET)
        begin
            @(negedge HCLK);
            cycles++;
            if (irq === 1'b1)
                seen = 1'b1;
        end
        if (seen)
            report_mismatch($sformatf("unexpected interrupt, pad %0d", pad), 32'd1, 32'd0);
    end
endtask

task automatic toggle_pad(input int pad);
    bit fires;
    @(negedge HCLK);
    gpio_in[pad] = ~gpio_in[pad];
    fires = edge_fires(pad, gpio_in[pad]);
    watch_irq(pad, fires);
    if (fires)
        status_m[pad] = 1'b1;
endtask

task automatic check_all_regs();
    logic [31:0] data;
    for (int i = 0; i < 32; i++)
    begin
        apb_read(5'(i), data);
        if (data !== expected_read(5'(i)))
            report_mismatch($sformatf("read of index %0d", i), data, expected_read(5'(i)));
    end
endtask

task automatic test_reset_readback();
    int errs;
    errs = errors;
    if (gpio_out !== '0 || gpio_dir !== '0 || irq !== 1'b0)
    begin
        $display("Outputs were not idle after reset at %0t", $time);
        errors++;
    end
    check_all_regs();
    dir_m     = lcg_next();
    en_m      = lcg_next();
    out_m     = lcg_next();
    inten_m   = lcg_next();
    type_lo_m = lcg_next();
    type_hi_m = lcg_next();
    apb_write(REG_PADDIR, dir_m);
    apb_write(REG_GPIOEN, en_m);
    apb_write(REG_PADOUT, out_m);
    apb_write(REG_INTEN, inten_m);
    apb_write(REG_INTTYPE_LO, type_lo_m);
    apb_write(REG_INTTYPE_HI, type_hi_m);
    if (gpio_dir !== dir_m)
        report_mismatch("gpio_dir", gpio_dir, dir_m);
    if (gpio_out !== out_m)
        report_mismatch("gpio_out", gpio_out, out_m);
    apb_write(5'd12, lcg_next());   // Unmapped
    apb_write(5'd31, lcg_next());
    apb_write(REG_PADIN, lcg_next());
    apb_write(REG_INTSTATUS, lcg_next());
    check_all_regs();
    finish_test("reset and readback", errs);
endtask

task automatic test_set_clear();
    int errs;
    logic [31:0] v;
    logic [31:0] data;
    errs = errors;
    for (int k = 0; k < 6; k++)
    begin
        v = lcg_next();
        apb_write(REG_PADOUTSET, v);
        out_m = out_m | v;
        if (gpio_out !== out_m)
            report_mismatch("gpio_out after set", gpio_out, out_m);
        v = lcg_next();
        apb_write(REG_PADOUTCLR, v);
        out_m = out_m & ~v;
        if (gpio_out !== out_m)
            report_mismatch("gpio_out after clear", gpio_out, out_m);
        apb_read(REG_PADOUT, data);
        if (data !== out_m)
            report_mismatch("PADOUT", data, out_m);
    end
    finish_test("set and clear", errs);
endtask

task automatic test_input_sampling();
    int errs;
    logic [31:0] data;
    errs = errors;
    apb_write(REG_INTEN, '0);
    inten_m = '0;
    apb_write(REG_GPIOEN, '1);
    en_m = '1;
    @(negedge HCLK);
    gpio_in = lcg_next();   // Preload every pad before half are disabled
    in_m = gpio_in;
    wait_sync(in_m);
    en_m = 32'h5555_5555;   // Every other pad
    apb_write(REG_GPIOEN, en_m);
    for (int k = 0; k < 6; k++)
    begin
        @(negedge HCLK);
        gpio_in = lcg_next();
        in_m = (gpio_in & en_m) | (in_m & ~en_m);
        wait_sync(in_m);
        apb_read(REG_PADIN, data);
        if (data !== in_m)
            report_mismatch("PADIN", data, in_m);
    end
    finish_test("input sampling", errs);
endtask

task automatic test_irq_types();
    int errs;
    logic [31:0] data;
    errs = errors;
    @(negedge HCLK);
    gpio_in = '0;
    apb_write(REG_GPIOEN, '1);
    en_m = '1;
    in_m = '0;
    wait_sync('0);
    apb_read(REG_INTSTATUS, data);
    if (data !== status_m)
        report_mismatch("INTSTATUS before test", data, status_m);
    status_m  = '0;
    type_lo_m = 32'hAAAA_E4E4;   // Pads 0-7 fall, rise, both, none; 8-15 both
    type_hi_m = '0;
    inten_m   = 32'h0000_00FF;
    apb_write(REG_INTTYPE_LO, type_lo_m);
    apb_write(REG_INTTYPE_HI, type_hi_m);
    apb_write(REG_INTEN, inten_m);
    for (int p = 0; p < 8; p++)
    begin
        toggle_pad(p);
        toggle_pad(p);
    end
    apb_read(REG_INTSTATUS, data);
    if (data !== status_m)
        report_mismatch("INTSTATUS", data, status_m);
    status_m = '0;
    finish_test("interrupt types", errs);
endtask

task automatic test_mask_clear_on_read();
    int errs;
    logic [31:0] data;
    errs = errors;
    for (int p = 8; p < 12; p++)
    begin
        toggle_pad(p);
        toggle_pad(p);
    end
    apb_read(REG_INTSTATUS, data);
    if (data !== '0)
        report_mismatch("INTSTATUS with inten clear", data, 32'd0);
    en_m = ~32'h0000_0004;   // Pad 2 disabled
    apb_write(REG_GPIOEN, en_m);
    toggle_pad(2);
    toggle_pad(2);
    en_m = '1;
    apb_write(REG_GPIOEN, en_m);
    toggle_pad(1);
    apb_read(REG_INTSTATUS, data);
    if (data !== status_m)
        report_mismatch("INTSTATUS first read", data, status_m);
    status_m = '0;
    apb_read(REG_INTSTATUS, data);
    if (data !== '0)
        report_mismatch("INTSTATUS second read", data, 32'd0);
    toggle_pad(1);
    finish_test("masking and clear", errs);
endtask

`endif

/* tb/tb_apb_gpio.sv */
// Testbench for the APB GPIO block, directed register and interrupt tests
`timescale 1ns/1ps

module tb_apb_gpio import gpio_pkg::*; ();

    localparam int HALF_PERIOD   = 50;
    localparam int SAMPLE_DELAY  = 10;
    localparam int READY_TIMEOUT = 4;
    localparam int SYNC_TIMEOUT  = 8;
    localparam int IRQ_TIMEOUT   = 8;
    localparam int IRQ_LATENCY   = 2;   // Cycles from pin change to interrupt
    localparam int IRQ_QUIET     = 6;
    localparam int WATCHDOG_NS   = 2_000_000;

    logic                      HCLK;
    logic                      HRESETn;
    logic [APB_ADDR_WIDTH-1:0] PADDR;
    logic [DATA_WIDTH-1:0]     PWDATA;
    logic [DATA_WIDTH-1:0]     PRDATA;
    logic                      PWRITE;
    logic                      PSEL;
    logic                      PENABLE;
    logic                      PREADY;
    logic                      PSLVERR;
    pad_vec_t                  gpio_in;
    pad_vec_t                  gpio_in_sync;
    pad_vec_t                  gpio_out;
    pad_vec_t                  gpio_dir;
    logic                      irq;

    // Reference model state
    pad_vec_t                  dir_m;
    pad_vec_t                  out_m;
    pad_vec_t                  en_m;
    pad_vec_t                  inten_m;
    pad_vec_t                  in_m;
    pad_vec_t                  status_m;
    logic [DATA_WIDTH-1:0]     type_lo_m;
    logic [DATA_WIDTH-1:0]     type_hi_m;

    logic [31:0]               lcg_state;
    int                        errors;
    int                        pass_count;
    int                        fail_count;

    always #HALF_PERIOD HCLK = ~HCLK;

    apb_gpio dut0 (
        .HCLK         (HCLK),
        .HRESETn      (HRESETn),
        .PADDR        (PADDR),
        .PWDATA       (PWDATA),
        .PWRITE       (PWRITE),
        .PSEL         (PSEL),
        .PENABLE      (PENABLE),
        .PRDATA       (PRDATA),
        .PREADY       (PREADY),
        .PSLVERR      (PSLVERR),
        .gpio_in      (gpio_in),
        .gpio_in_sync (gpio_in_sync),
        .gpio_out     (gpio_out),
        .gpio_dir     (gpio_dir),
        .interrupt    (irq)
    );

    // Value a read of this word index should return
    function automatic logic [DATA_WIDTH-1:0] expected_read(input logic [REG_IDX_WIDTH-1:0] idx);
        case (idx)
            REG_PADDIR:     return dir_m;
            REG_GPIOEN:     return en_m;
            REG_PADIN:      return in_m;
            REG_PADOUT:     return out_m;
            REG_INTEN:      return inten_m;
            REG_INTTYPE_LO: return type_lo_m;
            REG_INTTYPE_HI: return type_hi_m;
            REG_INTSTATUS:  return status_m;
            default:        return '0;
        endcase
    endfunction

    function automatic bit edge_fires(input int pad, input bit rising);
        int_type_e t;
        if (pad < TYPES_PER_WORD)
            t = int_type_e'(type_lo_m[2*pad +: 2]);
        else
            t = int_type_e'(type_hi_m[2*(pad-TYPES_PER_WORD) +: 2]);
        if (!en_m[pad] || !inten_m[pad])
            return 1'b0;
        if (t == INT_BOTH)
            return 1'b1;
        return rising ? (t == INT_RISE) : (t == INT_FALL);
    endfunction

    `include "tb_tasks.svh"

    initial
    begin
        #WATCHDOG_NS;
        $display("Timeout: simulation did not finish within %0d ns", WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

    initial
    begin
        HCLK      = 1'b0;
        HRESETn   = 1'b0;
        PADDR     = '0;
        PWDATA    = '0;
        PWRITE    = 1'b0;
        PSEL      = 1'b0;
        PENABLE   = 1'b0;
        gpio_in   = '0;
        lcg_state = 32'd92;
        errors    = 0;
        pass_count = 0;
        fail_count = 0;
        {dir_m, out_m, en_m, inten_m, in_m, status_m} = '0;
        {type_lo_m, type_hi_m} = '0;

        repeat (5) @(posedge HCLK);
        @(negedge HCLK);
        HRESETn = 1'b1;

        test_reset_readback();
        test_set_clear();
        test_input_sampling();
        test_irq_types();
        test_mask_clear_on_read();

        $display("Summary: %0d tests passed, %0d tests failed, %0d check errors",
                 pass_count, fail_count, errors);
        if (fail_count == 0 && errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

/* logic/apb_gpio.sv */
// APB GPIO top level for 32 pads with edge interrupts
`timescale 1ns/1ps

module apb_gpio import gpio_pkg::*;
(
    input  logic                      HCLK,
    input  logic                      HRESETn,

    input  logic [APB_ADDR_WIDTH-1:0] PADDR,
    input  logic [DATA_WIDTH-1:0]     PWDATA,
    input  logic                      PWRITE,
    input  logic                      PSEL,
    input  logic                      PENABLE,
    output logic [DATA_WIDTH-1:0]     PRDATA,
    output logic                      PREADY,
    output logic                      PSLVERR,

    input  pad_vec_t                  gpio_in,
    output pad_vec_t                  gpio_in_sync,
    output pad_vec_t                  gpio_out,
    output pad_vec_t                  gpio_dir,
    output logic                      interrupt
);

    apb_req_t  req;
    gpio_cfg_t cfg;
    pad_vec_t  sync;
    pad_vec_t  sampled;
    pad_vec_t  status;
    logic      status_rd;

    assign req = '{
        addr:   PADDR,
        wdata:  PWDATA,
        write:  PWRITE,
        sel:    PSEL,
        enable: PENABLE
    };

    apb_gpio_regs u_regs (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .req       (req),
        .sampled   (sampled),
        .status    (status),
        .rdata     (PRDATA),
        .cfg       (cfg),
        .status_rd (status_rd)
    );

    gpio_in_sync u_in_sync (
        .HCLK    (HCLK),
        .HRESETn (HRESETn),
        .pad_in  (gpio_in),
        .en      (cfg.en),
        .sync    (sync),
        .sampled (sampled)
    );

    gpio_irq u_irq (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .cfg       (cfg),
        .sync      (sync),
        .sampled   (sampled),
        .status_rd (status_rd),
        .status    (status),
        .interrupt (interrupt)
    );

    assign gpio_in_sync = sync;
    assign gpio_out     = cfg.out;
    assign gpio_dir     = cfg.dir;

    assign PREADY  = 1'b1;   // No wait states
    assign PSLVERR = 1'b0;

endmodule

/* logic/gpio_irq.sv */
// GPIO interrupt unit, edge detect per pad type with sticky status
`timescale 1ns/1ps

module gpio_irq import gpio_pkg::*;
(
    input  logic      HCLK,
    input  logic      HRESETn,

    input  gpio_cfg_t cfg,
    input  pad_vec_t  sync,
    input  pad_vec_t  sampled,
    input  logic      status_rd,

    output pad_vec_t  status,
    output logic      interrupt
);

    pad_vec_t rise;
    pad_vec_t fall;
    pad_vec_t hit;
    pad_vec_t event_vec;
    pad_vec_t status_q;

    assign rise =  sync & ~sampled;
    assign fall = ~sync &  sampled;

    always_comb
    begin
        for (int i = 0; i < PAD_NUM; i++)
        begin
            case (cfg.inttype[i])
                INT_FALL: hit[i] = fall[i];
                INT_RISE: hit[i] = rise[i];
                INT_BOTH: hit[i] = rise[i] | fall[i];
                default:  hit[i] = 1'b0;
            endcase
        end
    end

    assign event_vec = hit & cfg.inten & cfg.en;
    assign interrupt = |event_vec;

    // New events take priority over a clearing read
    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            status_q <= '0;
        end
        else if (interrupt)
        begin
            status_q <= status_q | event_vec;
        end
        else if (status_rd)
        begin
            status_q <= '0;
        end
    end

    assign status = status_q;

    a_irq_needs_enable: assert property (
        @(posedge HCLK) disable iff (!HRESETn)
        interrupt |-> |(cfg.inten & cfg.en)
    );

    a_status_masked: assert property (
        @(posedge HCLK) disable iff (!HRESETn)
        ((status & ~$past(status)) & ~$past(cfg.inten)) == '0
    );

endmodule

/* logic/gpio_in_sync.sv */
// GPIO input sampler, two-flop synchronizer plus history stage per enabled pad
`timescale 1ns/1ps

module gpio_in_sync import gpio_pkg::*;
(
    input  logic     HCLK,
    input  logic     HRESETn,

    input  pad_vec_t pad_in,
    input  pad_vec_t en,

    output pad_vec_t sync,
    output pad_vec_t sampled
);

    pad_vec_t stage0_q;
    pad_vec_t stage1_q;
    pad_vec_t stage2_q;

    // Disabled pads hold every stage
    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            stage0_q <= '0;
            stage1_q <= '0;
            stage2_q <= '0;
        end
        else
        begin
            stage0_q <= (pad_in   & en) | (stage0_q & ~en);
            stage1_q <= (stage0_q & en) | (stage1_q & ~en);
            stage2_q <= (stage1_q & en) | (stage2_q & ~en);
        end
    end

    assign sync    = stage1_q;   // Metastability-safe value
    assign sampled = stage2_q;   // Previous value for edge detect

    a_disabled_hold: assert property (
        @(posedge HCLK) disable iff (!HRESETn)
        ((sampled ^ $past(sampled)) & ~$past(en)) == '0
    );

endmodule

/* regs/apb_gpio_regs.sv */
// GPIO register file, decodes APB accesses and holds the pad configuration
`timescale 1ns/1ps

module apb_gpio_regs import gpio_pkg::*;
(
    input  logic                  HCLK,
    input  logic                  HRESETn,

    input  apb_req_t              req,
    input  pad_vec_t              sampled,
    input  pad_vec_t              status,

    output logic [DATA_WIDTH-1:0] rdata,
    output gpio_cfg_t             cfg,
    output logic                  status_rd
);

    logic [REG_IDX_WIDTH-1:0] idx;
    logic                     wr_acc;
    logic                     rd_acc;

    pad_vec_t                 dir_q;
    pad_vec_t                 out_q;
    pad_vec_t                 en_q;
    pad_vec_t                 inten_q;
    int_type_e [PAD_NUM-1:0]  inttype_q;

    assign idx    = req.addr[6:2];
    assign wr_acc = req.sel & req.enable & req.write;
    assign rd_acc = req.sel & req.enable & ~req.write;

    // Status clears at the end of this access cycle
    assign status_rd = rd_acc && (idx == REG_INTSTATUS);

    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            dir_q   <= '0;
            out_q   <= '0;
            en_q    <= '0;
            inten_q <= '0;
            for (int i = 0; i < PAD_NUM; i++)
            begin
                inttype_q[i] <= INT_FALL;
            end
        end
        else if (wr_acc)
        begin
            case (idx)
                REG_PADDIR:
                begin
                    dir_q <= req.wdata;
                end
                REG_GPIOEN:
                begin
                    en_q <= req.wdata;
                end
                REG_PADOUT:
                begin
                    out_q <= req.wdata;
                end
                REG_PADOUTSET:
                begin
                    out_q <= out_q | req.wdata;   // Set bits written as 1
                end
                REG_PADOUTCLR:
                begin
                    out_q <= out_q & ~req.wdata;  // Clear bits written as 1
                end
                REG_INTEN:
                begin
                    inten_q <= req.wdata;
                end
                REG_INTTYPE_LO:
                begin
                    for (int i = 0; i < TYPES_PER_WORD; i++)
                    begin
                        inttype_q[i] <=
                            int_type_e'(req.wdata[INT_TYPE_WIDTH*i +: INT_TYPE_WIDTH]);
                    end
                end
                REG_INTTYPE_HI:
                begin
                    for (int i = 0; i < TYPES_PER_WORD; i++)
                    begin
                        inttype_q[i+TYPES_PER_WORD] <=
                            int_type_e'(req.wdata[INT_TYPE_WIDTH*i +: INT_TYPE_WIDTH]);
                    end
                end
                default:
                begin
                    // PADIN, INTSTATUS and unmapped indexes ignore writes
                end
            endcase
        end
    end

    // Read mux, zero outside read access cycles
    always_comb
    begin
        rdata = '0;
        if (rd_acc)
        begin
            case (idx)
                REG_PADDIR:
                begin
                    rdata = dir_q;
                end
                REG_GPIOEN:
                begin
                    rdata = en_q;
                end
                REG_PADIN:
                begin
                    rdata = sampled;
                end
                REG_PADOUT:
                begin
                    rdata = out_q;
                end
                REG_INTEN:
                begin
                    rdata = inten_q;
                end
                REG_INTTYPE_LO:
                begin
                    for (int i = 0; i < TYPES_PER_WORD; i++)
                    begin
                        rdata[INT_TYPE_WIDTH*i +: INT_TYPE_WIDTH] = inttype_q[i];
                    end
                end
                REG_INTTYPE_HI:
                begin
                    for (int i = 0; i < TYPES_PER_WORD; i++)
                    begin
                        rdata[INT_TYPE_WIDTH*i +: INT_TYPE_WIDTH] =
                            inttype_q[i+TYPES_PER_WORD];
                    end
                end
                REG_INTSTATUS:
                begin
                    rdata = status;
                end
                default:
                begin
                    rdata = '0;   // Write-only and unmapped
                end
            endcase
        end
    end

    assign cfg = '{
        dir:     dir_q,
        out:     out_q,
        en:      en_q,
        inten:   inten_q,
        inttype: inttype_q
    };

    // PRDATA stays quiet on the bus unless a read is in its access cycle
    a_rdata_idle: assert property (
        @(posedge HCLK) disable iff (!HRESETn)
        !(req.sel && req.enable && !req.write) |-> (rdata == '0)
    );

endmodule

/* common/gpio_pkg.sv */
// GPIO package with the register map, widths, interrupt types and shared structs
package gpio_pkg;

    localparam int PAD_NUM        = 32;
    localparam int APB_ADDR_WIDTH = 12;
    localparam int DATA_WIDTH     = 32;
    localparam int REG_IDX_WIDTH  = 5;   // Word index, PADDR[6:2]

    // Interrupt type field layout inside the INTTYPE words
    localparam int INT_TYPE_WIDTH = 2;
    localparam int TYPES_PER_WORD = DATA_WIDTH / INT_TYPE_WIDTH;

    // Register word indexes
    localparam logic [REG_IDX_WIDTH-1:0] REG_PADDIR     = 5'd0;  // 0x00
    localparam logic [REG_IDX_WIDTH-1:0] REG_GPIOEN     = 5'd1;  // 0x04
    localparam logic [REG_IDX_WIDTH-1:0] REG_PADIN      = 5'd2;  // 0x08, read only
    localparam logic [REG_IDX_WIDTH-1:0] REG_PADOUT     = 5'd3;  // 0x0C
    localparam logic [REG_IDX_WIDTH-1:0] REG_PADOUTSET  = 5'd4;  // 0x10, write only
    localparam logic [REG_IDX_WIDTH-1:0] REG_PADOUTCLR  = 5'd5;  // 0x14, write only
    localparam logic [REG_IDX_WIDTH-1:0] REG_INTEN      = 5'd6;  // 0x18
    localparam logic [REG_IDX_WIDTH-1:0] REG_INTTYPE_LO = 5'd7;  // 0x1C, pads 0-15
    localparam logic [REG_IDX_WIDTH-1:0] REG_INTTYPE_HI = 5'd8;  // 0x20, pads 16-31
    localparam logic [REG_IDX_WIDTH-1:0] REG_INTSTATUS  = 5'd9;  // 0x24, clear on read

    typedef enum logic [INT_TYPE_WIDTH-1:0] {
        INT_FALL = 2'd0,
        INT_RISE = 2'd1,
        INT_BOTH = 2'd2,
        INT_NONE = 2'd3
    } int_type_e;

    typedef logic [PAD_NUM-1:0] pad_vec_t;

    // One APB transfer as seen in a single cycle
    typedef struct packed {
        logic [APB_ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0]     wdata;
        logic                      write;
        logic                      sel;
        logic                      enable;
    } apb_req_t;

    // Configuration held by the register file
    typedef struct packed {
        pad_vec_t                  dir;
        pad_vec_t                  out;
        pad_vec_t                  en;
        pad_vec_t                  inten;
        int_type_e [PAD_NUM-1:0]   inttype;
    } gpio_cfg_t;

endpackage
